/* source/isa_pkg.sv */
package isa_pkg;

	// base widths of the integer ISA
	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [31:0] instr_t;

	// major opcodes, instr[6:0]
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_branch = 7'b1100011;

	// alu funct3 codes, shared by reg and imm forms
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// branch funct3 codes
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// bit of funct7 that selects sub and sra
	localparam int funct7_alt_pos = 5;

endpackage

/* source/core_pkg.sv */
package core_pkg;

	// operation class carried from decode to execute
	typedef enum logic [2:0] {
		cls_reg,
		cls_imm,
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_branch,
		cls_none
	} op_class_t;

	// first fetch address out of reset
	localparam isa_pkg::word_t reset_pc = 32'h0000_0000;

	// sequential fetch step, also the jal link offset
	localparam isa_pkg::word_t pc_step = 32'd4;

endpackage

/* source/pipe_if.sv */
// decoded instruction bundle, decode to execute
interface decoded_if;
	import isa_pkg::*;
	import core_pkg::*;

	logic valid;
	op_class_t op_class;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	logic [2:0] funct3;
	logic alt;
	word_t imm;
	word_t pc;

	modport source (output valid, op_class, rs1, rs2, rd, funct3, alt, imm, pc);
	modport sink (input valid, op_class, rs1, rs2, rd, funct3, alt, imm, pc);
endinterface

// register file read ports, data comes back in the same cycle
interface regread_if;
	import isa_pkg::*;

	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t rs1_data;
	word_t rs2_data;

	modport source (output rs1, rs2, input rs1_data, rs2_data);
	modport target (input rs1, rs2, output rs1_data, rs2_data);
endinterface

/* source/fetch_unit.sv */
module fetch_unit (
	input logic clk,
	input logic reset,
	input logic i_redirect,
	input isa_pkg::word_t i_redirect_pc,
	output isa_pkg::word_t o_pc_addr,
	output logic o_pc_rd,
	output logic o_word_valid,
	output isa_pkg::word_t o_word_pc
);
	import core_pkg::*;

	isa_pkg::word_t pc;
	isa_pkg::word_t req_pc;
	logic run;
	logic req_valid;

	// pc and request tracking
	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			pc <= reset_pc;
			req_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (i_redirect) begin
				pc <= i_redirect_pc;
			end else if (run) begin
				pc <= pc + pc_step;
			end
			// a request issued under a redirect is already stale
			req_valid <= run && !i_redirect;
		end
	end

	// address of the word coming back next cycle
	always_ff @(posedge clk) begin
		req_pc <= pc;
	end

	assign o_pc_rd = run;
	assign o_pc_addr = pc;
	// word in flight during a redirect belongs to the wrong path
	assign o_word_valid = req_valid && !i_redirect;
	assign o_word_pc = req_pc;

endmodule

/* source/instr_decoder.sv */
module instr_decoder (
	input logic clk,
	input logic reset,
	input isa_pkg::instr_t i_instr,
	input logic i_word_valid,
	input isa_pkg::word_t i_word_pc,
	decoded_if.source dec
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	op_class_t cls;
	word_t imm_i;
	word_t imm_u;
	word_t imm_b;
	word_t imm_j;
	word_t imm;

	assign opcode = i_instr[6:0];
	assign funct7 = i_instr[31:25];

	// immediates for each kept format, sign extended from bit 31
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// opcode to class and immediate select
	always_comb begin
		case (opcode)
			op_reg: begin
				cls = cls_reg;
				imm = '0;
			end
			op_imm: begin
				cls = cls_imm;
				imm = imm_i;
			end
			op_lui: begin
				cls = cls_lui;
				imm = imm_u;
			end
			op_auipc: begin
				cls = cls_auipc;
				imm = imm_u;
			end
			op_jal: begin
				cls = cls_jal;
				imm = imm_j;
			end
			op_branch: begin
				cls = cls_branch;
				imm = imm_b;
			end
			// anything else runs as a no-op
			default: begin
				cls = cls_none;
				imm = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= i_word_valid;
		end
	end

	// decoded bundle payload
	always_ff @(posedge clk) begin
		dec.op_class <= cls;
		dec.rs1 <= i_instr[19:15];
		dec.rs2 <= i_instr[24:20];
		dec.rd <= i_instr[11:7];
		dec.funct3 <= i_instr[14:12];
		dec.alt <= funct7[funct7_alt_pos];
		dec.imm <= imm;
		dec.pc <= i_word_pc;
	end

endmodule

/* source/register_file.sv */
module register_file (
	input logic clk,
	input logic reset,
	regread_if.target rd,
	input logic i_wb_en,
	input isa_pkg::reg_addr_t i_wb_rd,
	input isa_pkg::word_t i_wb_data,
	output isa_pkg::word_t o_arch_regs [isa_pkg::reg_count]
);
	import isa_pkg::*;

	word_t regs [reg_count];

	// single write port, x0 stays at its reset value of zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_en && i_wb_rd != '0) begin
			regs[i_wb_rd] <= i_wb_data;
		end
	end

	// combinational read ports
	assign rd.rs1_data = regs[rd.rs1];
	assign rd.rs2_data = regs[rd.rs2];

	// debug view of the whole file
	always_comb begin
		for (int i = 0; i < reg_count; i++) begin
			o_arch_regs[i] = regs[i];
		end
	end

endmodule

/* source/execute_unit.sv */
module execute_unit (
	input logic clk,
	input logic reset,
	decoded_if.sink dec,
	regread_if.source rd,
	output logic o_redirect,
	output isa_pkg::word_t o_redirect_pc,
	output logic o_wb_en,
	output isa_pkg::reg_addr_t o_wb_rd,
	output isa_pkg::word_t o_wb_data
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t src1;
	word_t src2;
	word_t op_b;
	logic [4:0] shamt;
	word_t alu_out;
	word_t result;
	logic taken;
	logic writes;

	assign rd.rs1 = dec.rs1;
	assign rd.rs2 = dec.rs2;

	// forward from writeback stage when it targets our source
	always_comb begin
		if (o_wb_en && o_wb_rd != '0 && o_wb_rd == dec.rs1) begin
			src1 = o_wb_data;
		end else begin
			src1 = rd.rs1_data;
		end
		if (o_wb_en && o_wb_rd != '0 && o_wb_rd == dec.rs2) begin
			src2 = o_wb_data;
		end else begin
			src2 = rd.rs2_data;
		end
	end

	assign op_b = (dec.op_class == cls_reg) ? src2 : dec.imm;
	assign shamt = op_b[4:0];

	// alu, alt only means sub for the register form
	always_comb begin
		case (dec.funct3)
			f3_add: begin
				if (dec.op_class == cls_reg && dec.alt) begin
					alu_out = src1 - op_b;
				end else begin
					alu_out = src1 + op_b;
				end
			end
			f3_sll: alu_out = src1 << shamt;
			f3_slt: alu_out = {{(xlen-1){1'b0}}, $signed(src1) < $signed(op_b)};
			f3_sltu: alu_out = {{(xlen-1){1'b0}}, src1 < op_b};
			f3_xor: alu_out = src1 ^ op_b;
			f3_srl: begin
				if (dec.alt) begin
					alu_out = $signed(src1) >>> shamt;
				end else begin
					alu_out = src1 >> shamt;
				end
			end
			f3_or: alu_out = src1 | op_b;
			default: alu_out = src1 & op_b;
		endcase
	end

	// branch condition on the forwarded register values
	always_comb begin
		case (dec.funct3)
			f3_beq: taken = (src1 == src2);
			f3_bne: taken = (src1 != src2);
			f3_blt: taken = ($signed(src1) < $signed(src2));
			f3_bge: taken = ($signed(src1) >= $signed(src2));
			f3_bltu: taken = (src1 < src2);
			f3_bgeu: taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase
	end

	// result per class and whether it reaches the register file
	always_comb begin
		writes = 1'b1;
		case (dec.op_class)
			cls_lui: result = dec.imm;
			cls_auipc: result = dec.pc + dec.imm;
			cls_jal: result = dec.pc + pc_step;
			cls_reg, cls_imm: result = alu_out;
			default: begin
				result = alu_out;
				writes = 1'b0;
			end
		endcase
	end

	// jal and taken branches share the pc relative target
	assign o_redirect = dec.valid &&
		(dec.op_class == cls_jal || (dec.op_class == cls_branch && taken));
	assign o_redirect_pc = dec.pc + dec.imm;

	// stage four registers
	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb_en <= 1'b0;
		end else begin
			o_wb_en <= dec.valid && writes;
		end
	end

	always_ff @(posedge clk) begin
		o_wb_rd <= dec.rd;
		o_wb_data <= result;
	end

endmodule

/* source/riscv_core.sv */
module riscv_core (
	input logic clk,
	input logic reset,
	output isa_pkg::word_t o_pc_addr,
	output logic o_pc_rd,
	input isa_pkg::word_t i_pc_rddata,
	output isa_pkg::word_t o_arch_regs [isa_pkg::reg_count]
);
	import isa_pkg::*;

	logic word_valid;
	word_t word_pc;
	logic redirect;
	word_t redirect_pc;
	logic wb_en;
	reg_addr_t wb_rd;
	word_t wb_data;

	decoded_if dec_bus ();
	regread_if rd_bus ();

	fetch_unit u_fetch (
		.clk (clk),
		.reset (reset),
		.i_redirect (redirect),
		.i_redirect_pc (redirect_pc),
		.o_pc_addr (o_pc_addr),
		.o_pc_rd (o_pc_rd),
		.o_word_valid (word_valid),
		.o_word_pc (word_pc)
	);

	instr_decoder u_decode (
		.clk (clk),
		.reset (reset),
		.i_instr (i_pc_rddata),
		.i_word_valid (word_valid),
		.i_word_pc (word_pc),
		.dec (dec_bus.source)
	);

	execute_unit u_execute (
		.clk (clk),
		.reset (reset),
		.dec (dec_bus.sink),
		.rd (rd_bus.source),
		.o_redirect (redirect),
		.o_redirect_pc (redirect_pc),
		.o_wb_en (wb_en),
		.o_wb_rd (wb_rd),
		.o_wb_data (wb_data)
	);

	register_file u_regs (
		.clk (clk),
		.reset (reset),
		.rd (rd_bus.target),
		.i_wb_en (wb_en),
		.i_wb_rd (wb_rd),
		.i_wb_data (wb_data),
		.o_arch_regs (o_arch_regs)
	);

endmodule

/* tests/program_table.svh */
`ifndef program_table_svh
`define program_table_svh

// program length in words and number of checked registers
localparam int prog_len = 43;
localparam int row_count = 32;

typedef struct packed {
	reg_addr_t idx;
	word_t val;
} row_t;

word_t prog [prog_len];
row_t rows [row_count];

task automatic load_tables();
	prog = '{
		// seed values x1 = 5 and x2 = -3 in words 0 and 1
		alu_imm(f3_add, 1, 0, 12'h005), alu_imm(f3_add, 2, 0, 12'hffd),
		// word 2 takes x2 through forwarding
		alu_reg(f3_add, 0, 3, 1, 2), alu_reg(f3_add, 1, 4, 1, 2),
		alu_reg(f3_sll, 0, 5, 1, 1), alu_reg(f3_slt, 0, 6, 2, 1),
		alu_reg(f3_sltu, 0, 7, 2, 1), alu_reg(f3_xor, 0, 8, 1, 2),
		alu_reg(f3_srl, 0, 9, 2, 1), alu_reg(f3_srl, 1, 10, 2, 1),
		// word 11 takes x11 from word 10 on its first operand
		alu_reg(f3_or, 0, 11, 4, 3), alu_reg(f3_and, 0, 12, 11, 4),
		// immediate forms in words 12 to 19
		alu_imm(f3_slt, 13, 2, 12'hffe), alu_imm(f3_sltu, 14, 1, 12'hfff),
		alu_imm(f3_xor, 15, 1, 12'h0ff), alu_imm(f3_or, 16, 3, 12'h700),
		alu_imm(f3_and, 17, 2, 12'h0f0), alu_imm(f3_sll, 18, 1, 12'h003),
		alu_imm(f3_srl, 19, 2, 12'h01c), alu_imm(f3_srl, 20, 2, 12'h401),
		// lui and auipc at 0x54 then a write to x0
		upper_imm(op_lui, 21, 20'h12345), upper_imm(op_auipc, 22, 20'h00001),
		alu_imm(f3_add, 0, 1, 12'h007),
		// each branch jumps over the next two words when taken
		branch_to(f3_beq, 1, 1, 13'd12),
		alu_imm(f3_add, 23, 0, 12'h111), alu_imm(f3_add, 23, 0, 12'h222),
		branch_to(f3_bne, 1, 1, 13'd12), alu_imm(f3_add, 24, 0, 12'h333),
		branch_to(f3_blt, 2, 1, 13'd12),
		alu_imm(f3_add, 25, 0, 12'h444), alu_imm(f3_add, 25, 0, 12'h555),
		branch_to(f3_bge, 2, 1, 13'd12), alu_imm(f3_add, 26, 0, 12'h666),
		branch_to(f3_bltu, 1, 2, 13'd12),
		alu_imm(f3_add, 27, 0, 12'h777), alu_imm(f3_add, 27, 0, 12'h7aa),
		branch_to(f3_bgeu, 1, 2, 13'd12), alu_imm(f3_add, 28, 0, 12'h123),
		// jal at 0x98 links 0x9c and lands on word 41
		jump_to(29, 21'd12),
		alu_imm(f3_add, 30, 0, 12'h001), alu_imm(f3_add, 30, 0, 12'h002),
		alu_imm(f3_add, 31, 29, 12'h001), jump_to(0, 21'd0)
	};
	// x23, x25, x27 and x30 sit in the shadow of a taken transfer
	rows = '{
		{5'd0, 32'h0000_0000}, {5'd1, 32'h0000_0005}, {5'd2, 32'hffff_fffd}, {5'd3, 32'h0000_0002},
		{5'd4, 32'h0000_0008}, {5'd5, 32'h0000_00a0}, {5'd6, 32'h0000_0001}, {5'd7, 32'h0000_0000},
		{5'd8, 32'hffff_fff8}, {5'd9, 32'h07ff_ffff}, {5'd10, 32'hffff_ffff}, {5'd11, 32'h0000_000a},
		{5'd12, 32'h0000_0008}, {5'd13, 32'h0000_0001}, {5'd14, 32'h0000_0001}, {5'd15, 32'h0000_00fa},
		{5'd16, 32'h0000_0702}, {5'd17, 32'h0000_00f0}, {5'd18, 32'h0000_0028}, {5'd19, 32'h0000_000f},
		{5'd20, 32'hffff_fffe}, {5'd21, 32'h1234_5000}, {5'd22, 32'h0000_1054}, {5'd23, 32'h0000_0000},
		{5'd24, 32'h0000_0333}, {5'd25, 32'h0000_0000}, {5'd26, 32'h0000_0666}, {5'd27, 32'h0000_0000},
		{5'd28, 32'h0000_0123}, {5'd29, 32'h0000_009c}, {5'd30, 32'h0000_0000}, {5'd31, 32'h0000_009d}
	};
endtask

`endif

/* tests/core_tb.sv */
module core_tb;
	import isa_pkg::*;

	localparam int mem_words = 64;

	logic clk = 1'b0;
	logic reset = 1'b1;
	word_t pc_rddata = '0;
	word_t pc_addr;
	logic pc_rd;
	word_t arch_regs [reg_count];
	word_t mem [mem_words];

	riscv_core uut (
		.clk (clk),
		.reset (reset),
		.o_pc_addr (pc_addr),
		.o_pc_rd (pc_rd),
		.i_pc_rddata (pc_rddata),
		.o_arch_regs (arch_regs)
	);

	always #10 clk = ~clk;

	// instruction memory, word returned one cycle after the request
	always @(posedge clk) begin
		if (pc_rd) begin
			pc_rddata <= mem[pc_addr[7:2]];
		end
	end

	// instruction encoders, operands in assembly order
	function automatic word_t alu_reg(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
		reg_addr_t rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic word_t alu_imm(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic word_t upper_imm(logic [6:0] op, reg_addr_t rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic word_t branch_to(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic word_t jump_to(reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	`include "program_table.svh"

	// reset, program, settle margin and one cycle per row, plus slack
	localparam int watchdog_cycles = 16 + prog_len + 16 + row_count + 32;

	task automatic expect_equal(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	initial begin
		#(watchdog_cycles * 20);
		$display("timeout: the core did not get through the test program in time");
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		string what;
		word_t addr;
		load_tables();
		// unused words hold an unknown opcode built from their address
		for (int i = 0; i < mem_words; i++) begin
			addr = i * 4;
			mem[i] = {addr[24:0], 7'b0};
		end
		for (int i = 0; i < prog_len; i++) begin
			mem[i] = prog[i];
		end
		repeat (15) begin
			@(negedge clk);
			expect_equal(pc_rd, 1'b0, "o_pc_rd during reset");
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < reg_count; i++) begin
			expect_equal(arch_regs[i], '0, "register after reset");
		end
		expect_equal(pc_addr, 32'h0, "o_pc_addr after reset");
		while (!pc_rd) begin
			@(negedge clk);
		end
		// straight line fetch, first transfer is at word 23
		for (int k = 0; k < 8; k++) begin
			expect_equal(pc_addr, k * 4, "sequential fetch address");
			@(negedge clk);
		end
		repeat (prog_len + 16) @(posedge clk);
		for (int r = 0; r < row_count; r++) begin
			@(negedge clk);
			what = $sformatf("register x%0d", rows[r].idx);
			expect_equal(arch_regs[rows[r].idx], rows[r].val, what);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* build.f */
+incdir+tests
source/isa_pkg.sv
source/core_pkg.sv
source/pipe_if.sv
source/fetch_unit.sv
source/instr_decoder.sv
source/register_file.sv
source/execute_unit.sv
source/riscv_core.sv
tests/core_tb.sv
